/* rtl/riscv_isa_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32 F-extension encodings used by the fixed-point slice
// funct3 (rounding mode) is carried but never decoded
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package riscv_isa_pkg;

    // Major opcode
    localparam logic [6:0] opc_op_fp = 7'b10_100_11;    // OP_FP

    // funct7 codes inside OP_FP
    localparam logic [6:0] f7_fadd     = 7'b0000000;    // FADD.S
    localparam logic [6:0] f7_fsub     = 7'b0000100;    // FSUB.S
    localparam logic [6:0] f7_fmul     = 7'b0001000;    // FMUL.S
    localparam logic [6:0] f7_fcvt_s_w = 7'b1101000;    // FCVT.S.W / FCVT.S.WU
    localparam logic [6:0] f7_fcvt_w_s = 7'b1100000;    // FCVT.W.S / FCVT.WU.S
    localparam logic [6:0] f7_fmv_x_w  = 7'b1110000;    // FP bits to integer
    localparam logic [6:0] f7_fmv_w_x  = 7'b1111000;    // Integer bits to FP

    // rs2 field reused as conversion selector
    localparam logic [4:0] rs2_sel_signed   = 5'b00000; // W form, also moves
    localparam logic [4:0] rs2_sel_unsigned = 5'b00001; // WU form

    // R-type layout, MSB first
    typedef struct packed {
        logic [6:0] funct7;     // Operation select
        logic [4:0] rs2;        // Source 2 or selector
        logic [4:0] rs1;        // Source 1
        logic [2:0] funct3;     // Rounding mode, ignored
        logic [4:0] rd;         // Destination
        logic [6:0] opcode;     // Major opcode
    } r_type_t;

endpackage

/* rtl/fx_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Q21.10 fixed-point format and the slice's pipeline types
// No rounding, no saturation, no exception flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fx_pkg;

    localparam int xlen      = 32;  // Data width
    localparam int frac_bits = 10;  // Fraction bits of Q21.10

    // Micro-operations of the unit
    typedef enum logic [3:0] {
        op_add,                     // FADD.S
        op_sub,                     // FSUB.S
        op_mul,                     // FMUL.S
        op_cvt_from_int,            // FCVT.S.W
        op_cvt_from_uint,           // FCVT.S.WU
        op_cvt_to_int,              // FCVT.W.S
        op_cvt_to_uint,             // FCVT.WU.S
        op_mv_to_int,               // FMV.X.W
        op_mv_from_int              // FMV.W.X
    } fx_op_e;

    // Decoder to unit, E stage
    typedef struct packed {
        fx_op_e            op;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic              writes_fp;   // Result goes to FP file
        logic [xlen-1:0]   int_src;     // Integer operand of the instruction
        logic              bypass1;     // Take W data for operand a
        logic              bypass2;     // Take W data for operand b
    } fx_uop_t;

    // Unit to register file and top, W stage
    typedef struct packed {
        logic              fp_we;       // Destination is FP file
        logic              int_valid;   // Destination is integer port
        logic [4:0]        rd;
        logic [xlen-1:0]   data;
    } fx_wb_t;

endpackage

/* rtl/fx_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One instruction per cycle, never stalls
// Hazards on one-edge-old producers only, older ones use RF
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fx_decoder import riscv_isa_pkg::*, fx_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  r_type_t         instr,          // Sampled instruction word
    input  logic            instr_valid,
    input  logic [xlen-1:0] int_operand,    // Integer source, travels with instr
    input  logic [xlen-1:0] rdata1,         // Register file read data
    input  logic [xlen-1:0] rdata2,
    output logic [4:0]      raddr1,         // Register file read index
    output logic [4:0]      raddr2,
    output fx_uop_t         uop,            // E-stage micro-op
    output logic            uop_valid,
    output logic [xlen-1:0] op_a,           // Operands read at issue
    output logic [xlen-1:0] op_b,
    output logic            illegal         // One pulse per rejected word
);

    fx_op_e dec_op;         // Decoded operation
    logic   dec_fp;         // Result targets FP file
    logic   dec_legal;      // Encoding recognised
    logic   prev_fp_wr;     // E-stage uop will write an FP register

    assign raddr1 = instr.rs1;  // Read every cycle, consumed only if legal
    assign raddr2 = instr.rs2;

    always_comb begin
        dec_op    = op_add;
        dec_fp    = 1'b1;
        dec_legal = 1'b0;
        if (instr.opcode == opc_op_fp) begin
            case (instr.funct7)
                f7_fadd: begin
                    dec_op    = op_add;
                    dec_legal = 1'b1;
                end
                f7_fsub: begin
                    dec_op    = op_sub;
                    dec_legal = 1'b1;
                end
                f7_fmul: begin
                    dec_op    = op_mul;
                    dec_legal = 1'b1;
                end
                f7_fcvt_s_w: begin
                    dec_op    = (instr.rs2 == rs2_sel_unsigned) ? op_cvt_from_uint
                                                                : op_cvt_from_int;
                    dec_legal = (instr.rs2 == rs2_sel_signed) ||
                                (instr.rs2 == rs2_sel_unsigned);
                end
                f7_fcvt_w_s: begin
                    dec_op    = (instr.rs2 == rs2_sel_unsigned) ? op_cvt_to_uint
                                                                : op_cvt_to_int;
                    dec_fp    = 1'b0;           // Integer destination
                    dec_legal = (instr.rs2 == rs2_sel_signed) ||
                                (instr.rs2 == rs2_sel_unsigned);
                end
                f7_fmv_x_w: begin
                    dec_op    = op_mv_to_int;
                    dec_fp    = 1'b0;
                    dec_legal = (instr.rs2 == rs2_sel_signed);  // rs2 must be zero
                end
                f7_fmv_w_x: begin
                    dec_op    = op_mv_from_int;
                    dec_legal = (instr.rs2 == rs2_sel_signed);
                end
                default: dec_legal = 1'b0;      // Unknown funct7
            endcase
        end
    end

    // Producer one edge ahead sits in E now and reaches W with us
    assign prev_fp_wr = uop_valid && uop.writes_fp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop       <= '0;
            uop_valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            uop_valid     <= instr_valid && dec_legal;
            illegal       <= instr_valid && !dec_legal;
            uop.op        <= dec_op;
            uop.rd        <= instr.rd;
            uop.rs1       <= instr.rs1;
            uop.rs2       <= instr.rs2;
            uop.writes_fp <= dec_fp;
            uop.int_src   <= int_operand;
            uop.bypass1   <= prev_fp_wr && (uop.rd == instr.rs1);   // Unused operands ignored
            uop.bypass2   <= prev_fp_wr && (uop.rd == instr.rs2);
        end
    end

    always_ff @(posedge clk) begin
        op_a <= rdata1;     // Payload, qualified by uop_valid
        op_b <= rdata2;
    end

endmodule

/* rtl/fx_register_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 fixed-point registers, f0 is writable
// Reads are combinational and see a same-cycle write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fx_register_file import fx_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      raddr1,     // Read port 1 index
    input  logic [4:0]      raddr2,     // Read port 2 index
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    input  logic            we,         // Write strobe from W stage
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata
);

    logic [xlen-1:0] regs [0:31];   // Register array
    logic            hit1;          // Port 1 reads the write target
    logic            hit2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;      // All read zero after reset
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-first, covers a consumer two edges behind its producer
    assign hit1 = we && (waddr == raddr1);
    assign hit2 = we && (waddr == raddr2);

    assign rdata1 = hit1 ? wdata : regs[raddr1];
    assign rdata2 = hit2 ? wdata : regs[raddr2];

endmodule

/* rtl/fixed_point_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Q21.10 arithmetic that wraps or truncates silently
// Bypass selects come from the decoder and point at W data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fixed_point_unit import fx_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  fx_uop_t         uop,        // E-stage micro-op
    input  logic            uop_valid,
    input  logic [xlen-1:0] op_a,       // Stored register operands
    input  logic [xlen-1:0] op_b,
    output fx_wb_t          wb,         // W-stage result
    output logic            wb_valid
);

    logic        [xlen-1:0]   src_a;    // Operand after bypass
    logic        [xlen-1:0]   src_b;
    logic signed [2*xlen-1:0] prod;     // Full signed product
    logic signed [2*xlen-1:0] prod_sh;  // Product realigned to Q21.10
    logic        [xlen-1:0]   result;

    // Producer in W feeds the consumer in E
    assign src_a = uop.bypass1 ? wb.data : op_a;
    assign src_b = uop.bypass2 ? wb.data : op_b;

    assign prod    = $signed({{xlen{src_a[xlen-1]}}, src_a})    // Sign-extended operands
                   * $signed({{xlen{src_b[xlen-1]}}, src_b});
    assign prod_sh = prod >>> frac_bits;    // Drop the extra fraction bits

    always_comb begin
        case (uop.op)
            op_add:           result = src_a + src_b;              // Wraps
            op_sub:           result = src_a - src_b;              // Wraps
            op_mul:           result = prod_sh[xlen-1:0];          // Keep low word
            op_cvt_from_int:  result = $signed(uop.int_src) <<< frac_bits;
            op_cvt_from_uint: result = uop.int_src << frac_bits;
            op_cvt_to_int:    result = $signed(src_a) >>> frac_bits;   // Floors
            op_cvt_to_uint:   result = src_a >> frac_bits;
            op_mv_to_int:     result = src_a;                      // Raw bits
            op_mv_from_int:   result = uop.int_src;                // Raw bits
            default:          result = '0;
        endcase
    end

    // Destination kind is stored every cycle and qualified by wb_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb       <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid     <= uop_valid;
            wb.fp_we     <= uop.writes_fp;
            wb.int_valid <= !uop.writes_fp;
            wb.rd        <= uop.rd;
            wb.data      <= result;
        end
    end

endmodule

/* rtl/fx_exec_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-point execution slice, no back-pressure
// int_valid two edges after sample, illegal after one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fx_exec_top import riscv_isa_pkg::*, fx_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     instr,          // OP_FP instruction word
    input  logic            instr_valid,
    input  logic [31:0]     int_operand,    // Integer source for the word
    output logic [31:0]     int_result,
    output logic            int_valid,      // One-cycle result strobe
    output logic            illegal         // One-cycle reject strobe
);

    r_type_t         instr_f;   // Field view of instr
    logic [4:0]      raddr1;
    logic [4:0]      raddr2;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    fx_uop_t         uop;
    logic            uop_valid;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    fx_wb_t          wb;
    logic            wb_valid;

    assign instr_f    = r_type_t'(instr);
    assign int_result = wb.data;
    assign int_valid  = wb_valid && wb.int_valid;

    fx_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr_f),
        .instr_valid (instr_valid),
        .int_operand (int_operand),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .uop         (uop),
        .uop_valid   (uop_valid),
        .op_a        (op_a),
        .op_b        (op_b),
        .illegal     (illegal)
    );

    fx_register_file u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wb_valid && wb.fp_we),     // Single writer
        .waddr  (wb.rd),
        .wdata  (wb.data)
    );

    fixed_point_unit u_fpu (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop       (uop),
        .uop_valid (uop_valid),
        .op_a      (op_a),
        .op_b      (op_b),
        .wb        (wb),
        .wb_valid  (wb_valid)
    );

endmodule

/* tests/fx_exec_assertions.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks on the slice's output strobes
// Bound into every fx_exec_top instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fx_exec_assertions (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic int_valid,
    input logic illegal
);

    // A word yields a result or a reject, never both
    assert property (@(posedge clk) !(int_valid && illegal))
        else $error("int_valid and illegal high in the same cycle");

    assert property (@(posedge clk) !rst_n |-> (!int_valid && !illegal))
        else $error("output strobe high during reset");

    // Result arrives two edges after the sampled word
    assert property (@(posedge clk) disable iff (!rst_n) int_valid |-> $past(instr_valid, 2))
        else $error("int_valid without an instruction two edges earlier");

endmodule

bind fx_exec_top fx_exec_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .int_valid   (int_valid),
    .illegal     (illegal)
);

/* tests/fx_exec_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Runs from the project root, patterns in tests/fx_patterns.hex
// Test grouping below must match the pattern file line count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fx_exec_tb import fx_pkg::*; ();

    localparam int clk_half     = 50;   // 100 ns period
    localparam int drive_delay  = 5;    // Inputs change after the edge
    localparam int reset_cycles = 16;
    localparam int max_lines    = 24;   // Pattern capacity
    localparam int num_tests    = 5;
    localparam int test_len [num_tests] = '{1, 7, 8, 4, 4};    // Lines per test

    // One pending DUT response
    typedef struct packed {
        logic [31:0] kind;          // 1 int result, 2 illegal
        logic [31:0] value;         // Expected int_result
        logic [31:0] sample_edge;   // Edge that sampled the word
        logic [31:0] line;          // Pattern line, from 1
    } expect_t;

    logic            clk;
    logic            rst_n;
    logic [31:0]     instr;
    logic            instr_valid;
    logic [xlen-1:0] int_operand;
    logic [xlen-1:0] int_result;
    logic            int_valid;
    logic            illegal;

    logic [31:0] pat_mem [0:4*max_lines-1];    // Four words per line
    int          num_lines = 0;
    int          cycle_cnt = 0;
    int          err_cnt   = 0;
    logic        loaded    = 1'b0;
    expect_t     exp_q [$];                     // Responses in issue order

    fx_exec_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .int_operand (int_operand),
        .int_result  (int_result),
        .int_valid   (int_valid),
        .illegal     (illegal)
    );

    initial clk = 1'b0;
    always #clk_half clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;   // Edges seen so far

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %08h actual %08h", name, expected, actual);
            err_cnt++;
        end
    endtask

    function automatic string test_title(input int t);
        case (t)
            0:       return "registers after reset";
            1:       return "int conversions";
            2:       return "add sub mul";
            3:       return "back-to-back forwarding";
            4:       return "illegal encodings";
            default: return "unknown";
        endcase
    endfunction

    task automatic load_patterns();
        for (int i = 0; i < 4*max_lines; i++) begin
            pat_mem[i] = 32'hA5A5_0000 ^ 32'(i);   // Unread slots never look like a kind
        end
        $readmemh("tests/fx_patterns.hex", pat_mem);
        while (num_lines < max_lines && pat_mem[4*num_lines+2] <= 32'd2) begin
            num_lines++;
        end
        loaded = 1'b1;
    endtask

    task automatic issue_line(input int idx);
        expect_t e;
        @(posedge clk);
        #drive_delay;
        instr        = pat_mem[4*idx];
        instr_valid  = 1'b1;
        int_operand  = pat_mem[4*idx+1];
        e.kind        = pat_mem[4*idx+2];
        e.value       = pat_mem[4*idx+3];
        e.sample_edge = 32'(cycle_cnt + 1);     // Next edge samples it
        e.line        = 32'(idx + 1);
        if (e.kind != 32'd0) exp_q.push_back(e);
    endtask

    task automatic go_idle();
        @(posedge clk);
        #drive_delay;
        instr       = '0;
        instr_valid = 1'b0;
        int_operand = '0;
    endtask

    task automatic drain_expected();
        while (exp_q.size() != 0) @(negedge clk);  // Watchdog bounds this
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        expect_t e;
        int      lat;
        if (rst_n && (int_valid || illegal)) begin
            if (exp_q.size() == 0) begin
                $display("unexpected output pulse at edge %0d with nothing pending", cycle_cnt);
                err_cnt++;
            end else begin
                e   = exp_q.pop_front();
                lat = cycle_cnt - int'(e.sample_edge) + 1;
                check_value($sformatf("output kind (line %0d)", e.line), e.kind,
                            illegal ? 32'd2 : 32'd1);
                if (int_valid) begin
                    check_value($sformatf("int_result (line %0d)", e.line), e.value, int_result);
                end
                check_value($sformatf("latency (line %0d)", e.line),
                            (e.kind == 32'd2) ? 32'd1 : 32'd2, 32'(lat));
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat ((num_lines + reset_cycles) * 20) @(posedge clk);
        $display("timeout at edge %0d, responses still pending: %0d", cycle_cnt, exp_q.size());
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int line_idx;
        int total;
        int errs_before;
        int tests_failed;
        rst_n        = 1'b0;
        instr        = '0;
        instr_valid  = 1'b0;
        int_operand  = '0;
        line_idx     = 0;
        total        = 0;
        tests_failed = 0;
        load_patterns();
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        check_value("int_valid", 32'd0, {31'd0, int_valid});   // Strobes clear out of reset
        check_value("illegal", 32'd0, {31'd0, illegal});
        for (int t = 0; t < num_tests; t++) total += test_len[t];
        if (total != num_lines) begin
            $display("pattern file holds %0d lines but the tests need %0d", num_lines, total);
            err_cnt++;
        end else begin
            for (int t = 0; t < num_tests; t++) begin
                errs_before = err_cnt;
                for (int k = 0; k < test_len[t]; k++) begin
                    issue_line(line_idx);
                    line_idx++;
                end
                go_idle();          // Gap keeps tests independent
                drain_expected();
                if (err_cnt != errs_before) tests_failed++;
                $display("test %0d %s: %0d lines, %0d errors", t + 1, test_title(t),
                         test_len[t], err_cnt - errs_before);
            end
        end
        repeat (4) @(posedge clk);  // Catch stray pulses
        $display("tests %0d, tests failed %0d, errors %0d", num_tests, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* tests/fx_patterns.hex */
// Columns: instr, int_operand, kind (0 none, 1 int_result, 2 illegal), expected int_result
// Lines run back to back inside a test, tests are 1, 7, 8, 4 and 4 lines long
// test 1: registers after reset
E00F8053 00000000 1 00000000  // fmv.x.w f31
// test 2: int conversions
D00000D3 00000005 0 00000000  // fcvt.s.w f1, 5
E0008053 00000000 1 00001400  // fmv.x.w f1, bypass
C0008053 00000000 1 00000005  // fcvt.w.s f1, write-first
D0000153 FFFFFFFD 0 00000000  // fcvt.s.w f2, -3
C0010053 00000000 1 FFFFFFFD  // fcvt.w.s f2
D01001D3 003C0002 0 00000000  // fcvt.s.wu f3, top bit set after shift
C0118053 00000000 1 003C0002  // fcvt.wu.s f3, logical shift
// test 3: add sub mul
F00002D3 00000600 0 00000000  // fmv.w.x f5, 1.5
F0000353 FFFFF600 0 00000000  // fmv.w.x f6, -2.5
006283D3 00000000 0 00000000  // fadd f7 = f5 + f6
08628453 00000000 0 00000000  // fsub f8 = f5 - f6
106284D3 00000000 0 00000000  // fmul f9 = f5 * f6
E0038053 00000000 1 FFFFFC00  // fmv.x.w f7, -1.0
E0040053 00000000 1 00001000  // fmv.x.w f8, 4.0
E0048053 00000000 1 FFFFF100  // fmv.x.w f9, -3.75
// test 4: back-to-back forwarding
F0000553 7FFFFC00 0 00000000  // fmv.w.x f10
00A505D3 00000000 0 00000000  // fadd f11 = f10 + f10, wraps
C0058053 00000000 1 FFFFFFFE  // fcvt.w.s f11, one edge behind
E0058053 00000000 1 FFFFF800  // fmv.x.w f11, two edges behind
// test 5: illegal encodings
000006B3 00000000 2 00000000  // OP opcode, rd f13
200006D3 00000000 2 00000000  // unknown funct7
D02006D3 00000007 2 00000000  // fcvt.s.w with rs2 selector 2
E0068053 00000000 1 00000000  // fmv.x.w f13 unchanged

/* tb.f */
rtl/riscv_isa_pkg.sv
rtl/fx_pkg.sv
rtl/fx_decoder.sv
rtl/fx_register_file.sv
rtl/fixed_point_unit.sv
rtl/fx_exec_top.sv
tests/fx_exec_assertions.sv
tests/fx_exec_tb.sv

/* Makefile */
# Verilator flow for the fixed-point execution slice
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= fx_exec_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All tests passed
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
